/* tester_macros.svh */
`ifndef TESTER_MACROS_SVH
`define TESTER_MACROS_SVH

// sdram word sizes
`define ADDR_W 22
`define DATA_W 16

// characters on the serial line
`define ASCII_ZERO 8'h30
`define ASCII_ONE  8'h31
`define ASCII_CR   8'h0D

// menu keys
`define KEY_WRITE 8'h31    // "1"
`define KEY_READ  8'h32    // "2"

// bytes the uart transmitter can buffer
`define TX_CREDITS 4

`endif

/* sdram_pkg.sv */
`default_nettype none

package sdram_pkg;

`include "tester_macros.svh"

  typedef logic [`ADDR_W-1:0] sdram_addr_t;    // row, bank and column together
  typedef logic [`DATA_W-1:0] sdram_data_t;

endpackage

`default_nettype wire

/* tester_pkg.sv */
`default_nettype none

package tester_pkg;

  typedef logic [7:0] byte_t;

  typedef enum logic [2:0] {
    welcome,       // start the menu text
    choose,        // wait for a menu key
    get_data,
    get_waddr,
    write_issue,
    get_raddr,
    read_wait,     // read request held until data comes back
    report         // last message of an operation
  } menu_state_t;

  typedef enum logic [2:0] {
    msg_menu,
    msg_data,
    msg_addr,
    msg_ok,
    msg_read       // text followed by the read word
  } msg_id_t;

endpackage

`default_nettype wire

/* bit_string_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tester_macros.svh"

module bit_string_receiver
  import tester_pkg::*;
#(
  parameter type payload_t = byte_t
)
(
  input  wire        clk,
  input  wire        reset,
  input  wire        enable,
  input  wire        rx_valid,
  input  wire byte_t rx_data,
  output payload_t   payload,
  output logic       full,
  output logic       echo_valid,
  output byte_t      echo_byte,
  input  wire        echo_grant
);

  localparam int W     = $bits(payload_t);
  localparam int CNT_W = $clog2(W + 1);

  logic [W-1:0]     shift_q;
  logic [CNT_W-1:0] count_q;
  logic             is_bit;
  logic             accept;
  logic             last;

  assign is_bit  = (rx_data == `ASCII_ZERO) || (rx_data == `ASCII_ONE);
  assign accept  = enable && rx_valid && is_bit && !echo_valid;    // one echo in flight at most
  assign last    = (count_q == CNT_W'(W - 1));
  assign full    = accept && last;
  assign payload = payload_t'(shift_q);

  always_ff @(posedge clk or posedge reset)
    if (reset)
    begin
      count_q    <= '0;
      echo_valid <= 1'b0;
    end
    else
    begin
      if (!enable)
        count_q <= '0;
      else if (accept)
        count_q <= last ? '0 : count_q + 1'b1;
      if (accept)
        echo_valid <= 1'b1;
      else if (echo_grant)
        echo_valid <= 1'b0;
    end

  always_ff @(posedge clk)
    if (accept)
    begin
      shift_q   <= {shift_q[W-2:0], rx_data[0]};    // msb typed first
      echo_byte <= rx_data;
    end

endmodule

`default_nettype wire

/* message_sender.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tester_macros.svh"

module message_sender
  import sdram_pkg::*, tester_pkg::*;
(
  input  wire              clk,
  input  wire              reset,
  input  wire              msg_start,
  input  wire msg_id_t     msg_id,
  input  wire sdram_data_t read_data,
  output logic             msg_valid,
  output byte_t            msg_byte,
  input  wire              msg_grant,
  output logic             msg_done
);

  localparam int TEXT_LEN   = 15;
  localparam int PREFIX_LEN = 5;    // "Read:" ahead of the bits

  logic                    busy_q;
  logic [4:0]              idx_q;
  logic [4:0]              last_idx;
  logic [4:0]              bit_idx;
  msg_id_t                 id_q;
  logic [8*TEXT_LEN-1:0]   text;

  // texts are left aligned with the first character in the top byte
  function automatic logic [8*TEXT_LEN-1:0] text_of(input msg_id_t id);
    case (id)
      msg_menu: return {"1-Write 2-Read", `ASCII_CR};
      msg_data: return {"Data:", {10{8'h00}}};
      msg_addr: return {"Addr:", {10{8'h00}}};
      msg_ok:   return {"OK", `ASCII_CR, {12{8'h00}}};
      default:  return {"Read:", {10{8'h00}}};
    endcase
  endfunction

  always_comb
    case (id_q)
      msg_menu: last_idx = 5'(TEXT_LEN - 1);
      msg_ok:   last_idx = 5'd2;
      msg_read: last_idx = 5'(PREFIX_LEN + `DATA_W);    // bits then cr
      default:  last_idx = 5'(PREFIX_LEN - 1);
    endcase

  assign text      = text_of(id_q);
  assign bit_idx   = idx_q - 5'(PREFIX_LEN);
  assign msg_valid = busy_q;

  always_comb
    if (id_q == msg_read && idx_q == last_idx)
      msg_byte = `ASCII_CR;
    else if (id_q == msg_read && idx_q >= 5'(PREFIX_LEN))
      msg_byte = read_data[`DATA_W - 1 - int'(bit_idx)] ? `ASCII_ONE : `ASCII_ZERO;
    else
      msg_byte = text[8*(TEXT_LEN - 1 - int'(idx_q)) +: 8];

  always_ff @(posedge clk or posedge reset)
    if (reset)
    begin
      busy_q   <= 1'b0;
      idx_q    <= '0;
      id_q     <= msg_menu;
      msg_done <= 1'b0;
    end
    else
    begin
      msg_done <= 1'b0;
      if (msg_start)
      begin
        busy_q <= 1'b1;
        idx_q  <= '0;
        id_q   <= msg_id;
      end
      else if (msg_grant)
      begin
        if (idx_q == last_idx)
        begin
          busy_q   <= 1'b0;
          msg_done <= 1'b1;
        end
        else
          idx_q <= idx_q + 1'b1;
      end
    end

endmodule

`default_nettype wire

/* tx_credit_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tester_macros.svh"

module tx_credit_arbiter
  import tester_pkg::*;
(
  input  wire        clk,
  input  wire        reset,
  input  wire        echo_valid,
  input  wire byte_t echo_byte,
  output logic       echo_grant,
  input  wire        msg_valid,
  input  wire byte_t msg_byte,
  output logic       msg_grant,
  output logic       tx_valid,
  output byte_t      tx_data,
  input  wire        tx_credit
);

  localparam int CW = $clog2(`TX_CREDITS + 1);

  logic [CW-1:0] credit_q;
  logic          has_credit;
  logic          send;

  assign has_credit = (credit_q != '0);
  assign echo_grant = has_credit && echo_valid;
  assign msg_grant  = has_credit && msg_valid && !echo_valid;    // echo goes first
  assign send       = echo_grant || msg_grant;

  // credit is taken at grant so a second grant cannot overrun the uart
  always_ff @(posedge clk or posedge reset)
    if (reset)
    begin
      credit_q <= CW'(`TX_CREDITS);
      tx_valid <= 1'b0;
    end
    else
    begin
      tx_valid <= send;
      case ({send, tx_credit})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end

  always_ff @(posedge clk)
    if (send)
      tx_data <= echo_grant ? echo_byte : msg_byte;

endmodule

`default_nettype wire

/* menu_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tester_macros.svh"

module menu_fsm
  import sdram_pkg::*, tester_pkg::*;
(
  input  wire              clk,
  input  wire              reset,
  input  wire              rx_valid,
  input  wire byte_t       rx_data,
  output logic             msg_start,
  output msg_id_t          msg_id,
  input  wire              msg_done,
  output logic             data_enable,
  input  wire              data_full,
  input  wire sdram_data_t data_word,
  output logic             addr_enable,
  input  wire              addr_full,
  input  wire sdram_addr_t addr_word,
  output sdram_addr_t      sys_addr,
  output sdram_data_t      sys_data_to_sdram,
  output logic             sys_write_rq,
  output logic             sys_read_rq,
  input  wire sdram_data_t sys_data_from_sdram,
  input  wire              sys_data_from_sdram_valid,
  output sdram_data_t      read_data
);

  menu_state_t state_q;
  logic        msg_wait_q;    // a message is still going out

  assign data_enable       = (state_q == get_data) && !msg_wait_q;
  assign addr_enable       = (state_q inside {get_waddr, get_raddr}) && !msg_wait_q;
  assign sys_write_rq      = (state_q == write_issue);
  assign sys_read_rq       = (state_q == read_wait);
  assign sys_addr          = (sys_write_rq || sys_read_rq) ? addr_word : '0;
  assign sys_data_to_sdram = sys_write_rq ? data_word : '0;

  always_ff @(posedge clk or posedge reset)
    if (reset)
    begin
      state_q    <= welcome;
      msg_start  <= 1'b0;
      msg_id     <= msg_menu;
      msg_wait_q <= 1'b0;
    end
    else
    begin
      msg_start <= 1'b0;
      if (msg_done)
        msg_wait_q <= 1'b0;
      case (state_q)
        welcome:
        begin
          msg_start  <= 1'b1;
          msg_id     <= msg_menu;
          msg_wait_q <= 1'b1;
          state_q    <= choose;
        end
        choose:
          if (!msg_wait_q && rx_valid && (rx_data == `KEY_WRITE || rx_data == `KEY_READ))
          begin
            msg_start  <= 1'b1;
            msg_wait_q <= 1'b1;
            msg_id     <= (rx_data == `KEY_WRITE) ? msg_data : msg_addr;
            state_q    <= (rx_data == `KEY_WRITE) ? get_data : get_raddr;
          end
        get_data:
          if (data_full)
          begin
            msg_start  <= 1'b1;
            msg_id     <= msg_addr;
            msg_wait_q <= 1'b1;
            state_q    <= get_waddr;
          end
        get_waddr:
          if (addr_full)
            state_q <= write_issue;
        write_issue:
        begin
          msg_start  <= 1'b1;    // write pulse lasts this one cycle
          msg_id     <= msg_ok;
          msg_wait_q <= 1'b1;
          state_q    <= report;
        end
        get_raddr:
          if (addr_full)
            state_q <= read_wait;
        read_wait:
          if (sys_data_from_sdram_valid)
          begin
            msg_start  <= 1'b1;
            msg_id     <= msg_read;
            msg_wait_q <= 1'b1;
            state_q    <= report;
          end
        report:
          if (!msg_wait_q)
            state_q <= welcome;
        default:
          state_q <= welcome;
      endcase
    end

  always_ff @(posedge clk)
    if (sys_read_rq && sys_data_from_sdram_valid)
      read_data <= sys_data_from_sdram;

endmodule

`default_nettype wire

/* sdram_tester_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_tester_top
  import sdram_pkg::*, tester_pkg::*;
(
  input  wire              clk,
  input  wire              reset,
  input  wire              rx_valid,
  input  wire byte_t       rx_data,
  output logic             tx_valid,
  output byte_t            tx_data,
  input  wire              tx_credit,
  output sdram_addr_t      sys_addr,
  output sdram_data_t      sys_data_to_sdram,
  output logic             sys_write_rq,
  output logic             sys_read_rq,
  input  wire sdram_data_t sys_data_from_sdram,
  input  wire              sys_data_from_sdram_valid
);

  logic        msg_start;
  msg_id_t     msg_id;
  logic        msg_done;
  logic        msg_valid;
  byte_t       msg_byte;
  logic        msg_grant;
  sdram_data_t read_data;

  logic        data_enable;
  logic        data_full;
  sdram_data_t data_word;
  logic        data_echo_valid;
  byte_t       data_echo_byte;
  logic        data_echo_grant;

  logic        addr_enable;
  logic        addr_full;
  sdram_addr_t addr_word;
  logic        addr_echo_valid;
  byte_t       addr_echo_byte;
  logic        addr_echo_grant;

  logic        echo_valid;
  byte_t       echo_byte;
  logic        echo_grant;

  // only one receiver can hold an echo at a time
  assign echo_valid      = data_echo_valid || addr_echo_valid;
  assign echo_byte       = data_echo_valid ? data_echo_byte : addr_echo_byte;
  assign data_echo_grant = echo_grant && data_echo_valid;
  assign addr_echo_grant = echo_grant && !data_echo_valid;

  menu_fsm u_menu_fsm (
    .clk                       (clk),
    .reset                     (reset),
    .rx_valid                  (rx_valid),
    .rx_data                   (rx_data),
    .msg_start                 (msg_start),
    .msg_id                    (msg_id),
    .msg_done                  (msg_done),
    .data_enable               (data_enable),
    .data_full                 (data_full),
    .data_word                 (data_word),
    .addr_enable               (addr_enable),
    .addr_full                 (addr_full),
    .addr_word                 (addr_word),
    .sys_addr                  (sys_addr),
    .sys_data_to_sdram         (sys_data_to_sdram),
    .sys_write_rq              (sys_write_rq),
    .sys_read_rq               (sys_read_rq),
    .sys_data_from_sdram       (sys_data_from_sdram),
    .sys_data_from_sdram_valid (sys_data_from_sdram_valid),
    .read_data                 (read_data)
  );

  message_sender u_message_sender (
    .clk       (clk),
    .reset     (reset),
    .msg_start (msg_start),
    .msg_id    (msg_id),
    .read_data (read_data),
    .msg_valid (msg_valid),
    .msg_byte  (msg_byte),
    .msg_grant (msg_grant),
    .msg_done  (msg_done)
  );

  bit_string_receiver #(.payload_t(sdram_data_t)) u_data_rx (
    .clk        (clk),
    .reset      (reset),
    .enable     (data_enable),
    .rx_valid   (rx_valid),
    .rx_data    (rx_data),
    .payload    (data_word),
    .full       (data_full),
    .echo_valid (data_echo_valid),
    .echo_byte  (data_echo_byte),
    .echo_grant (data_echo_grant)
  );

  // shared by the write and the read address
  bit_string_receiver #(.payload_t(sdram_addr_t)) u_addr_rx (
    .clk        (clk),
    .reset      (reset),
    .enable     (addr_enable),
    .rx_valid   (rx_valid),
    .rx_data    (rx_data),
    .payload    (addr_word),
    .full       (addr_full),
    .echo_valid (addr_echo_valid),
    .echo_byte  (addr_echo_byte),
    .echo_grant (addr_echo_grant)
  );

  tx_credit_arbiter u_tx_credit_arbiter (
    .clk        (clk),
    .reset      (reset),
    .echo_valid (echo_valid),
    .echo_byte  (echo_byte),
    .echo_grant (echo_grant),
    .msg_valid  (msg_valid),
    .msg_byte   (msg_byte),
    .msg_grant  (msg_grant),
    .tx_valid   (tx_valid),
    .tx_data    (tx_data),
    .tx_credit  (tx_credit)
  );

endmodule

`default_nettype wire

/* sdram_tester_sva.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tester_macros.svh"

module sdram_tester_sva
  import sdram_pkg::*;
(
  input wire              clk,
  input wire              reset,
  input wire              tx_valid,
  input wire              tx_credit,
  input wire              sys_write_rq,
  input wire              sys_read_rq,
  input wire sdram_addr_t sys_addr
);

  int outstanding_q;    // bytes sent and not yet credited back

  always_ff @(posedge clk or posedge reset)
    if (reset)
      outstanding_q <= 0;
    else
      outstanding_q <= outstanding_q + (tx_valid ? 1 : 0) - (tx_credit ? 1 : 0);

  a_credit_limit: assert property (@(posedge clk) disable iff (reset)
    outstanding_q <= `TX_CREDITS)
    else $error("more bytes outstanding than transmit credits");

  a_one_request: assert property (@(posedge clk) disable iff (reset)
    !(sys_write_rq && sys_read_rq))
    else $error("write and read requests high together");

  a_write_pulse: assert property (@(posedge clk) disable iff (reset)
    sys_write_rq |=> !sys_write_rq)
    else $error("write request longer than one cycle");

  a_idle_addr: assert property (@(posedge clk) disable iff (reset)
    !(sys_write_rq || sys_read_rq) |-> (sys_addr == '0))
    else $error("sys_addr not zero with no request");

endmodule

bind sdram_tester_top sdram_tester_sva u_sdram_tester_sva (
  .clk          (clk),
  .reset        (reset),
  .tx_valid     (tx_valid),
  .tx_credit    (tx_credit),
  .sys_write_rq (sys_write_rq),
  .sys_read_rq  (sys_read_rq),
  .sys_addr     (sys_addr)
);

`default_nettype wire

/* tb_sdram_tester.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tester_macros.svh"

module tb_sdram_tester
  import sdram_pkg::*, tester_pkg::*;
();

  localparam int CLK_PERIOD       = 10;
  localparam int RESET_CYCLES     = 5;
  localparam int MAX_CREDIT_DELAY = 8;
  localparam int WAIT_LIMIT       = 200;    // cycles allowed for any single byte
  localparam int STALL_CYCLES     = 40;
  localparam int TEST_BYTES       = 440;    // everything the five tests print and type
  localparam int WATCHDOG_CYCLES  = 2 * (TEST_BYTES * (MAX_CREDIT_DELAY + 4) + 2 * STALL_CYCLES);

  localparam string MENU_TEXT = "1-Write 2-Read";
  localparam byte_t LINE_END  = 8'h0D;
  localparam byte_t CH_ZERO   = "0";
  localparam byte_t CH_ONE    = "1";
  localparam byte_t CH_WRITE  = "1";
  localparam byte_t CH_READ   = "2";

  logic        clk;
  logic        reset;
  logic        rx_valid;
  byte_t       rx_data;
  logic        tx_valid;
  byte_t       tx_data;
  logic        tx_credit;
  sdram_addr_t sys_addr;
  sdram_data_t sys_data_to_sdram;
  logic        sys_write_rq;
  logic        sys_read_rq;
  sdram_data_t sys_data_from_sdram;
  logic        sys_data_from_sdram_valid;

  integer      seed = 20;
  byte_t       tx_q[$];
  int unsigned credit_due_q[$];      // cycle at which each credit goes back
  int          outstanding = 0;
  int unsigned cycle_n = 0;
  bit          hold_credits = 1'b0;
  sdram_data_t mem [sdram_addr_t];
  int          write_count = 0;
  int          read_count = 0;
  bit          write_prev = 1'b0;
  sdram_addr_t last_write_addr;
  sdram_data_t last_write_data;
  bit          read_busy = 1'b0;
  sdram_addr_t read_addr;
  int          read_left = 0;

  sdram_tester_top u_sdram_tester_top (
    .clk                       (clk),
    .reset                     (reset),
    .rx_valid                  (rx_valid),
    .rx_data                   (rx_data),
    .tx_valid                  (tx_valid),
    .tx_data                   (tx_data),
    .tx_credit                 (tx_credit),
    .sys_addr                  (sys_addr),
    .sys_data_to_sdram         (sys_data_to_sdram),
    .sys_write_rq              (sys_write_rq),
    .sys_read_rq               (sys_read_rq),
    .sys_data_from_sdram       (sys_data_from_sdram),
    .sys_data_from_sdram_valid (sys_data_from_sdram_valid)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_with_failure(input string msg);
    begin
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "stopped at the first error");
    end
  endtask

  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp)
      stop_with_failure($sformatf("MISMATCH at %0t ns: %s got 0x%02h expected 0x%02h",
                                  $time, what, got, exp));
  endtask

  task automatic check_addr(input sdram_addr_t got, input sdram_addr_t exp, input string what);
    if (got !== exp)
      stop_with_failure($sformatf("MISMATCH at %0t ns: %s got 0x%06h expected 0x%06h",
                                  $time, what, got, exp));
  endtask

  task automatic check_data(input sdram_data_t got, input sdram_data_t exp, input string what);
    if (got !== exp)
      stop_with_failure($sformatf("MISMATCH at %0t ns: %s got 0x%04h expected 0x%04h",
                                  $time, what, got, exp));
  endtask

  // uart transmitter model collects bytes and hands credits back in order
  always @(posedge clk)
  begin : uart_tx_model
    int unsigned delay;
    bit          give;
    cycle_n++;
    give = 1'b0;
    if (tx_valid)
    begin
      tx_q.push_back(tx_data);
      delay = 1 + ($unsigned($random(seed)) % MAX_CREDIT_DELAY);
      credit_due_q.push_back(cycle_n + delay);
      outstanding++;
      if (outstanding > `TX_CREDITS)
        stop_with_failure("the tester sent a byte while it held no credit");
    end
    if (!hold_credits && credit_due_q.size() > 0 && credit_due_q[0] <= cycle_n)
    begin
      void'(credit_due_q.pop_front());
      outstanding--;
      give = 1'b1;
    end
    #1;
    tx_credit = give;
  end

  // sdram model stores writes in mem and answers reads after 3 to 6 cycles
  always @(posedge clk)
  begin : sdram_model
    bit answer;
    answer = 1'b0;
    if (sys_write_rq && sys_read_rq)
      stop_with_failure("write and read requests were high in the same cycle");
    if (sys_write_rq && write_prev)
      stop_with_failure("the write request lasted more than one cycle");
    if (!sys_write_rq && !sys_read_rq)
      check_addr(sys_addr, '0, "sys_addr with no request");
    write_prev = sys_write_rq;
    if (sys_write_rq)
    begin
      mem[sys_addr]   = sys_data_to_sdram;
      last_write_addr = sys_addr;
      last_write_data = sys_data_to_sdram;
      write_count++;
    end
    if (sys_read_rq)
    begin
      if (!read_busy)
      begin
        read_busy = 1'b1;
        read_addr = sys_addr;
        read_left = 3 + int'($unsigned($random(seed)) % 4);
        read_count++;
      end
      else
        check_addr(sys_addr, read_addr, "sys_addr while the read is held");
      read_left--;
      answer = (read_left == 0);
    end
    else
      read_busy = 1'b0;
    #1;
    sys_data_from_sdram_valid = answer;
    sys_data_from_sdram = (answer && mem.exists(read_addr)) ? mem[read_addr] : '0;
  end

  task automatic send_char(input byte_t c);
    begin
      @(posedge clk);
      #1;
      rx_valid = 1'b1;
      rx_data  = c;
      @(posedge clk);
      #1;
      rx_valid = 1'b0;
    end
  endtask

  task automatic next_tx_byte(output byte_t b);
    int waited;
    begin
      waited = 0;
      while (tx_q.size() == 0)
      begin
        @(posedge clk);
        #1;
        waited++;
        if (waited > WAIT_LIMIT)
          stop_with_failure("timed out waiting for a byte from the tester");
      end
      b = tx_q.pop_front();
    end
  endtask

  task automatic expect_text(input string s, input bit with_cr);
    byte_t b;
    begin
      for (int i = 0; i < s.len(); i++)
      begin
        next_tx_byte(b);
        check_byte(b, byte_t'(s[i]), $sformatf("character %0d of %s", i, s));
      end
      if (with_cr)
      begin
        next_tx_byte(b);
        check_byte(b, LINE_END, $sformatf("line end after %s", s));
      end
    end
  endtask

  // msb first and each bit waits for its echo before the next one goes out
  task automatic type_bits(input logic [31:0] value, input int width, input bit with_noise);
    byte_t c;
    byte_t b;
    begin
      for (int i = width - 1; i >= 0; i--)
      begin
        if (with_noise)
          send_char((i % 2 == 0) ? byte_t'("z") : CH_READ);    // not bits so never echoed
        c = value[i] ? CH_ONE : CH_ZERO;
        send_char(c);
        next_tx_byte(b);
        check_byte(b, c, $sformatf("echo of bit %0d", i));
      end
    end
  endtask

  task automatic wait_credits_home();
    int waited;
    begin
      waited = 0;
      while (credit_due_q.size() != 0)
      begin
        @(posedge clk);
        #1;
        waited++;
        if (waited > WAIT_LIMIT)
          stop_with_failure("timed out waiting for all credits to return");
      end
    end
  endtask

  task automatic menu_after_reset();
    begin
      if (sys_write_rq !== 1'b0 || sys_read_rq !== 1'b0 || tx_valid !== 1'b0)
        stop_with_failure("an output was active right after reset");
      expect_text(MENU_TEXT, 1'b1);
    end
  endtask

  task automatic finish_write(input sdram_data_t data, input sdram_addr_t addr);
    int writes_before;
    begin
      writes_before = write_count;
      type_bits(data, `DATA_W, 1'b1);
      expect_text("Addr:", 1'b0);
      type_bits(addr, `ADDR_W, 1'b0);
      expect_text("OK", 1'b1);
      if (write_count != writes_before + 1)
        stop_with_failure($sformatf("MISMATCH at %0t ns: %0d write requests, expected 1",
                                    $time, write_count - writes_before));
      check_addr(last_write_addr, addr, "write address");
      check_data(last_write_data, data, "write data");
      expect_text(MENU_TEXT, 1'b1);
    end
  endtask

  task automatic write_word(input sdram_data_t data, input sdram_addr_t addr);
    begin
      send_char(CH_WRITE);
      expect_text("Data:", 1'b0);
      finish_write(data, addr);
    end
  endtask

  task automatic read_word(input sdram_addr_t addr, input sdram_data_t exp_data);
    int    reads_before;
    byte_t b;
    begin
      reads_before = read_count;
      send_char(CH_READ);
      expect_text("Addr:", 1'b0);
      type_bits(addr, `ADDR_W, 1'b0);
      expect_text("Read:", 1'b0);
      for (int i = `DATA_W - 1; i >= 0; i--)
      begin
        next_tx_byte(b);
        check_byte(b, exp_data[i] ? CH_ONE : CH_ZERO, $sformatf("reported bit %0d", i));
      end
      next_tx_byte(b);
      check_byte(b, LINE_END, "line end after the read word");
      if (read_count != reads_before + 1)
        stop_with_failure($sformatf("MISMATCH at %0t ns: %0d read requests, expected 1",
                                    $time, read_count - reads_before));
      check_addr(read_addr, addr, "read address");
      expect_text(MENU_TEXT, 1'b1);
    end
  endtask

  task automatic starve_credits(input sdram_data_t data, input sdram_addr_t addr);
    string prompt;
    byte_t b;
    begin
      prompt = "Data:";
      wait_credits_home();
      hold_credits = 1'b1;
      send_char(CH_WRITE);
      for (int i = 0; i < `TX_CREDITS; i++)
      begin
        next_tx_byte(b);
        check_byte(b, byte_t'(prompt[i]), $sformatf("starved prompt character %0d", i));
      end
      repeat (STALL_CYCLES) @(posedge clk);
      #1;
      if (tx_q.size() != 0)
        stop_with_failure("bytes kept coming after every credit was used up");
      hold_credits = 1'b0;
      next_tx_byte(b);
      check_byte(b, byte_t'(prompt[`TX_CREDITS]), "prompt character after credit release");
      finish_write(data, addr);
    end
  endtask

  task automatic ignore_unknown_key(input sdram_addr_t addr, input sdram_data_t exp_data);
    int writes_before;
    int reads_before;
    begin
      writes_before = write_count;
      reads_before  = read_count;
      send_char("7");
      repeat (STALL_CYCLES) @(posedge clk);
      #1;
      if (tx_q.size() != 0)
        stop_with_failure("the tester printed something after an unknown menu key");
      if (write_count != writes_before || read_count != reads_before)
        stop_with_failure("an unknown menu key caused an sdram request");
      read_word(addr, exp_data);
    end
  endtask

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_with_failure("watchdog expired before the tests finished");
  end

  initial
  begin
    rx_valid                  = 1'b0;
    rx_data                   = '0;
    tx_credit                 = 1'b0;
    sys_data_from_sdram       = '0;
    sys_data_from_sdram_valid = 1'b0;
    reset                     = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;

    menu_after_reset();
    write_word(16'hA5C3, 22'h2A5F31);
    read_word(22'h2A5F31, 16'hA5C3);
    starve_credits(16'h3C0F, 22'h012345);
    ignore_unknown_key(22'h012345, 16'h3C0F);

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
sdram_pkg.sv
tester_pkg.sv
bit_string_receiver.sv
message_sender.sv
tx_credit_arbiter.sv
menu_fsm.sv
sdram_tester_top.sv
sdram_tester_sva.sv
tb_sdram_tester.sv

/* run.sh */
#!/bin/sh
# build and run the sdram tester testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sdram_tester -f compile.f -o sim_sdram_tester
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_sdram_tester 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1
